// File: pad_settings.svh
//////////////////////////////////////////////////
// Pad ring settings
// Pad counts, JTAG pin map and pad variant tables
//////////////////////////////////////////////////

`ifndef PAD_SETTINGS_SVH
`define PAD_SETTINGS_SVH

// Pad counts
`define PAD_NUM_MIO 16 // Multiplexed pads, one word
`define PAD_NUM_DIO 6  // SPI device pads with 0-3 data, 4 CSB and 5 SCK

// JTAG overlay pin map on the MIO pads
`define JTAG_EN_IDX   7  // Strap pin
`define JTAG_TCK_IDX  8
`define JTAG_TMS_IDX  9
`define JTAG_TRST_IDX 10
`define JTAG_TDI_IDX  11
`define JTAG_TDO_IDX  4

// Variant tables with 2 bits per pad and pad 0 in the low bits
// Encodings are 0 bidir, 1 input only, 3 open drain

// MIO 12-15 open drain and MIO 0-11 bidir
`define PAD_MIO_VARIANTS {{4{2'd3}}, {12{2'd0}}}

// CSB and SCK input only and SPI data bidir
`define PAD_DIO_VARIANTS {{2{2'd1}}, {4{2'd0}}}

`endif

// File: pad_pkg.sv
//////////////////////////////////////////////////
// Pad level types and the pad variant rules
//////////////////////////////////////////////////

`include "pad_settings.svh"

package pad_pkg;

  typedef logic [`PAD_NUM_MIO-1:0] mio_vec_t; // One bit per MIO pad
  typedef logic [`PAD_NUM_DIO-1:0] dio_vec_t; // One bit per DIO pad

  typedef enum logic [1:0] {
    PAD_BIDIR      = 2'd0,
    PAD_INPUT      = 2'd1, // Receiver only
    PAD_OPEN_DRAIN = 2'd3  // Only pulls low
  } pad_variant_e;

  typedef struct packed {
    logic dp; // Positive line
    logic dn; // Negative line
  } usb_pair_t;

  // Value driven onto the pad
  function automatic logic pad_out_val(pad_variant_e variant, logic out, logic inv);
    logic res;
    res = (variant == PAD_BIDIR) ? (out ^ inv) : 1'b0; // Open drain drives a 0
    return res;
  endfunction

  // Driver enable of the pad
  function automatic logic pad_oe_val(pad_variant_e variant, logic out, logic oe, logic inv);
    logic res;
    case (variant)
      PAD_BIDIR:      res = oe;
      PAD_OPEN_DRAIN: res = oe & ~(out ^ inv); // Enable only to pull low
      default:        res = 1'b0;              // Input only
    endcase
    return res;
  endfunction

endpackage

// File: jtag_pkg.sv
//////////////////////////////////////////////////
// JTAG overlay types
//////////////////////////////////////////////////

package jtag_pkg;

  // Overlay mode taken from the strap pin
  typedef enum logic {
    JTAG_OFF = 1'b0, // Pins pass through
    JTAG_ON  = 1'b1  // Pins belong to JTAG
  } jtag_mode_e;

  typedef logic [3:0] pin_idx_t; // Index of an MIO pin

endpackage

// File: pad_sync.sv
//////////////////////////////////////////////////
// Two flop synchronizer for pad input levels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_sync #(
  parameter type      payload_t = logic,
  parameter payload_t ResetVal  = '0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  payload_t d_i,   // Asynchronous pad level
  output payload_t q_o    // Synchronized level
);

  payload_t meta_q; // First stage may go metastable
  payload_t sync_q; // Second stage

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_q <= ResetVal;
      sync_q <= ResetVal;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

// File: pad_drv.sv
//////////////////////////////////////////////////
// Pad drivers
// Variant and invert rules with registered pad side
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pad_settings.svh"

module pad_drv (
  input  logic              clk_i,
  input  logic              rst_i,
  input  pad_pkg::mio_vec_t mio_sync_i,    // Synchronized MIO pads
  input  pad_pkg::dio_vec_t dio_sync_i,    // Synchronized DIO pads
  input  pad_pkg::mio_vec_t mio_inv_i,
  input  pad_pkg::dio_vec_t dio_inv_i,
  input  pad_pkg::mio_vec_t mio_out_i,     // After the JTAG mux
  input  pad_pkg::mio_vec_t mio_oe_i,
  input  pad_pkg::dio_vec_t dio_out_i,
  input  pad_pkg::dio_vec_t dio_oe_i,
  output pad_pkg::mio_vec_t mio_in_o,      // Inverted inputs
  output pad_pkg::dio_vec_t dio_in_o,
  output pad_pkg::mio_vec_t mio_pad_out_o,
  output pad_pkg::mio_vec_t mio_pad_oe_o,
  output pad_pkg::dio_vec_t dio_pad_out_o,
  output pad_pkg::dio_vec_t dio_pad_oe_o
);

  import pad_pkg::*;

  localparam logic [2*`PAD_NUM_MIO-1:0] MioVariants = `PAD_MIO_VARIANTS;
  localparam logic [2*`PAD_NUM_DIO-1:0] DioVariants = `PAD_DIO_VARIANTS;

  mio_vec_t mio_out_d, mio_oe_d, mio_out_q, mio_oe_q;
  dio_vec_t dio_out_d, dio_oe_d, dio_out_q, dio_oe_q;

  // Inbound side
  assign mio_in_o = mio_sync_i ^ mio_inv_i;
  assign dio_in_o = dio_sync_i ^ dio_inv_i;

  //////////////////////////////////////////////////
  // Outbound variant rules
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `PAD_NUM_MIO; i++) begin
      mio_out_d[i] = pad_out_val(pad_variant_e'(MioVariants[2*i +: 2]), mio_out_i[i],
                                 mio_inv_i[i]);
      mio_oe_d[i]  = pad_oe_val(pad_variant_e'(MioVariants[2*i +: 2]), mio_out_i[i],
                                mio_oe_i[i], mio_inv_i[i]);
    end
    for (int i = 0; i < `PAD_NUM_DIO; i++) begin
      dio_out_d[i] = pad_out_val(pad_variant_e'(DioVariants[2*i +: 2]), dio_out_i[i],
                                 dio_inv_i[i]);
      dio_oe_d[i]  = pad_oe_val(pad_variant_e'(DioVariants[2*i +: 2]), dio_out_i[i],
                                dio_oe_i[i], dio_inv_i[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mio_out_q <= '0; // Pads float out of reset
      mio_oe_q  <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
    end else begin
      mio_out_q <= mio_out_d;
      mio_oe_q  <= mio_oe_d;
      dio_out_q <= dio_out_d;
      dio_oe_q  <= dio_oe_d;
    end
  end

  assign mio_pad_out_o = mio_out_q;
  assign mio_pad_oe_o  = mio_oe_q;
  assign dio_pad_out_o = dio_out_q;
  assign dio_pad_oe_o  = dio_oe_q;

endmodule

// File: jtag_overlay_ctrl.sv
//////////////////////////////////////////////////
// JTAG overlay control
// Registers the strap pin into the overlay mode
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pad_settings.svh"

module jtag_overlay_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  pad_pkg::mio_vec_t    mio_sync_i,    // Inverted synchronized MIO inputs
  output jtag_pkg::jtag_mode_e jtag_mode_o,
  output logic                 jtag_active_o  // Mode seen from outside
);

  import jtag_pkg::*;

  localparam pin_idx_t EnIdx = pin_idx_t'(`JTAG_EN_IDX);

  jtag_mode_e mode_d, mode_q;

  // Strap high selects JTAG
  assign mode_d = mio_sync_i[EnIdx] ? JTAG_ON : JTAG_OFF;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_q <= JTAG_OFF; // Ring comes up in pass through
    end else begin
      mode_q <= mode_d;
    end
  end

  assign jtag_mode_o   = mode_q;
  assign jtag_active_o = (mode_q == JTAG_ON);

endmodule

// File: jtag_overlay_mux.sv
//////////////////////////////////////////////////
// JTAG overlay mux
// Routes the JTAG pins and ties off the core side
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pad_settings.svh"

module jtag_overlay_mux (
  input  jtag_pkg::jtag_mode_e jtag_mode_i,
  input  pad_pkg::mio_vec_t    mio_in_pad_i,    // Inverted pad inputs
  input  pad_pkg::mio_vec_t    mio_out_core_i,
  input  pad_pkg::mio_vec_t    mio_oe_core_i,
  input  logic                 jtag_tdo_i,
  output pad_pkg::mio_vec_t    mio_in_core_o,
  output pad_pkg::mio_vec_t    mio_out_pad_o,   // Toward the pad drivers
  output pad_pkg::mio_vec_t    mio_oe_pad_o,
  output logic                 jtag_tck_o,
  output logic                 jtag_tms_o,
  output logic                 jtag_trst_no,
  output logic                 jtag_tdi_o
);

  import jtag_pkg::*;

  localparam pin_idx_t TckIdx  = pin_idx_t'(`JTAG_TCK_IDX);
  localparam pin_idx_t TmsIdx  = pin_idx_t'(`JTAG_TMS_IDX);
  localparam pin_idx_t TrstIdx = pin_idx_t'(`JTAG_TRST_IDX);
  localparam pin_idx_t TdiIdx  = pin_idx_t'(`JTAG_TDI_IDX);
  localparam pin_idx_t TdoIdx  = pin_idx_t'(`JTAG_TDO_IDX);

  logic jtag_on;

  assign jtag_on = (jtag_mode_i == JTAG_ON);

  //////////////////////////////////////////////////
  // Pin takeover
  //////////////////////////////////////////////////

  always_comb begin
    mio_in_core_o = mio_in_pad_i;   // Pass through by default
    mio_out_pad_o = mio_out_core_i;
    mio_oe_pad_o  = mio_oe_core_i;
    if (jtag_on) begin
      // JTAG inputs are never driven and read 0 in the core
      mio_oe_pad_o[TckIdx]   = 1'b0;
      mio_oe_pad_o[TmsIdx]   = 1'b0;
      mio_oe_pad_o[TrstIdx]  = 1'b0;
      mio_oe_pad_o[TdiIdx]   = 1'b0;
      mio_in_core_o[TckIdx]  = 1'b0;
      mio_in_core_o[TmsIdx]  = 1'b0;
      mio_in_core_o[TrstIdx] = 1'b0;
      mio_in_core_o[TdiIdx]  = 1'b0;
      // TDO owns its pad
      mio_out_pad_o[TdoIdx]  = jtag_tdo_i;
      mio_oe_pad_o[TdoIdx]   = 1'b1;
      mio_in_core_o[TdoIdx]  = 1'b0;
    end
  end

  // JTAG side held low while off
  assign jtag_tck_o   = jtag_on & mio_in_pad_i[TckIdx];
  assign jtag_tms_o   = jtag_on & mio_in_pad_i[TmsIdx];
  assign jtag_trst_no = jtag_on & mio_in_pad_i[TrstIdx]; // TAP held in reset
  assign jtag_tdi_o   = jtag_on & mio_in_pad_i[TdiIdx];

endmodule

// File: usb_diff_rx.sv
//////////////////////////////////////////////////
// USB differential receiver
// Decodes data and SE0 from the line pair
//////////////////////////////////////////////////

`timescale 1ns/1ps

module usb_diff_rx (
  input  logic               clk_i,
  input  logic               rst_i,
  input  pad_pkg::usb_pair_t usb_pad_i,   // Raw line pair
  input  logic               usb_rx_en_i,
  output logic               usb_d_o,     // Received data bit
  output logic               usb_se0_o    // Both lines low
);

  import pad_pkg::*;

  usb_pair_t usb_sync;
  logic      d_q, se0_q;

  pad_sync #(
    .payload_t ( usb_pair_t ),
    .ResetVal  ( '0         )
  ) u_usb_sync (
    .clk_i ( clk_i     ),
    .rst_i ( rst_i     ),
    .d_i   ( usb_pad_i ),
    .q_o   ( usb_sync  )
  );

  // Decoder outputs drop to 0 when disabled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_q   <= 1'b0;
      se0_q <= 1'b0;
    end else begin
      d_q   <= usb_rx_en_i & usb_sync.dp;
      se0_q <= usb_rx_en_i & ~usb_sync.dp & ~usb_sync.dn;
    end
  end

  assign usb_d_o   = d_q;
  assign usb_se0_o = se0_q;

endmodule

// File: pad_ring_top.sv
//////////////////////////////////////////////////
// Pad ring top
// Synchronizers, pad drivers, JTAG overlay and USB
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_ring_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Pad side
  input  pad_pkg::mio_vec_t    mio_pad_in_i,
  input  pad_pkg::dio_vec_t    dio_pad_in_i,
  input  pad_pkg::usb_pair_t   usb_pad_i,
  output pad_pkg::mio_vec_t    mio_pad_out_o,
  output pad_pkg::mio_vec_t    mio_pad_oe_o,
  output pad_pkg::dio_vec_t    dio_pad_out_o,
  output pad_pkg::dio_vec_t    dio_pad_oe_o,
  // Core side
  input  pad_pkg::mio_vec_t    mio_out_i,
  input  pad_pkg::mio_vec_t    mio_oe_i,
  input  pad_pkg::mio_vec_t    mio_inv_i,     // Per pad invert attribute
  input  pad_pkg::dio_vec_t    dio_out_i,
  input  pad_pkg::dio_vec_t    dio_oe_i,
  input  pad_pkg::dio_vec_t    dio_inv_i,
  output pad_pkg::mio_vec_t    mio_in_o,
  output pad_pkg::dio_vec_t    dio_in_o,
  // JTAG side
  output logic                 jtag_tck_o,
  output logic                 jtag_tms_o,
  output logic                 jtag_trst_no,
  output logic                 jtag_tdi_o,
  input  logic                 jtag_tdo_i,
  output logic                 jtag_active_o,
  // USB side
  input  logic                 usb_rx_en_i,
  output logic                 usb_d_o,
  output logic                 usb_se0_o
);

  import pad_pkg::*;
  import jtag_pkg::*;

  mio_vec_t   mio_sync;       // Raw synchronized MIO
  dio_vec_t   dio_sync;
  mio_vec_t   mio_pad_sync;   // Synchronized and inverted
  mio_vec_t   mio_out_mux;    // Core outputs after the overlay
  mio_vec_t   mio_oe_mux;
  jtag_mode_e jtag_mode;

  //////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////

  pad_sync #(
    .payload_t ( mio_vec_t ),
    .ResetVal  ( '0        )
  ) u_mio_sync (
    .clk_i ( clk_i        ),
    .rst_i ( rst_i        ),
    .d_i   ( mio_pad_in_i ),
    .q_o   ( mio_sync     )
  );

  pad_sync #(
    .payload_t ( dio_vec_t ),
    .ResetVal  ( '0        )
  ) u_dio_sync (
    .clk_i ( clk_i        ),
    .rst_i ( rst_i        ),
    .d_i   ( dio_pad_in_i ),
    .q_o   ( dio_sync     )
  );

  //////////////////////////////////////////////////
  // Pad drivers and JTAG overlay
  //////////////////////////////////////////////////

  pad_drv u_pad_drv (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .mio_sync_i    ( mio_sync      ),
    .dio_sync_i    ( dio_sync      ),
    .mio_inv_i     ( mio_inv_i     ),
    .dio_inv_i     ( dio_inv_i     ),
    .mio_out_i     ( mio_out_mux   ),
    .mio_oe_i      ( mio_oe_mux    ),
    .dio_out_i     ( dio_out_i     ),
    .dio_oe_i      ( dio_oe_i      ),
    .mio_in_o      ( mio_pad_sync  ),
    .dio_in_o      ( dio_in_o      ), // DIO bypasses the overlay
    .mio_pad_out_o ( mio_pad_out_o ),
    .mio_pad_oe_o  ( mio_pad_oe_o  ),
    .dio_pad_out_o ( dio_pad_out_o ),
    .dio_pad_oe_o  ( dio_pad_oe_o  )
  );

  jtag_overlay_ctrl u_jtag_ctrl (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .mio_sync_i    ( mio_pad_sync  ),
    .jtag_mode_o   ( jtag_mode     ),
    .jtag_active_o ( jtag_active_o )
  );

  jtag_overlay_mux u_jtag_mux (
    .jtag_mode_i    ( jtag_mode    ),
    .mio_in_pad_i   ( mio_pad_sync ),
    .mio_out_core_i ( mio_out_i    ),
    .mio_oe_core_i  ( mio_oe_i     ),
    .jtag_tdo_i     ( jtag_tdo_i   ),
    .mio_in_core_o  ( mio_in_o     ),
    .mio_out_pad_o  ( mio_out_mux  ),
    .mio_oe_pad_o   ( mio_oe_mux   ),
    .jtag_tck_o     ( jtag_tck_o   ),
    .jtag_tms_o     ( jtag_tms_o   ),
    .jtag_trst_no   ( jtag_trst_no ),
    .jtag_tdi_o     ( jtag_tdi_o   )
  );

  // USB receiver has its own synchronizer
  usb_diff_rx u_usb_rx (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .usb_pad_i   ( usb_pad_i   ),
    .usb_rx_en_i ( usb_rx_en_i ),
    .usb_d_o     ( usb_d_o     ),
    .usb_se0_o   ( usb_se0_o   )
  );

endmodule

// File: tb_pad_ring_sva.sv
//////////////////////////////////////////////////
// Pad ring assertions
// Variant limits and the JTAG reset hold
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pad_ring_sva (
  input logic              clk_i,
  input logic              rst_i,
  input pad_pkg::mio_vec_t mio_pad_out_o,
  input pad_pkg::dio_vec_t dio_pad_out_o,
  input pad_pkg::dio_vec_t dio_pad_oe_o,
  input logic              jtag_trst_no,
  input logic              jtag_active_o
);

  import pad_pkg::*;

  localparam mio_vec_t OpenDrainMask = 16'hF000; // MIO 12-15
  localparam dio_vec_t InputMask     = 6'b110000; // CSB and SCK

  int fail_cnt = 0; // Failed assertion count

  // Receiver only pads never drive
  input_oe_low: assert property (@(posedge clk_i) disable iff (rst_i)
    (dio_pad_oe_o & InputMask) == '0)
    else begin
      fail_cnt++;
      $error("Input only DIO pad has its driver enabled");
    end

  input_out_low: assert property (@(posedge clk_i) disable iff (rst_i)
    (dio_pad_out_o & InputMask) == '0)
    else begin
      fail_cnt++;
      $error("Input only DIO pad drives a high level");
    end

  // Open drain only ever pulls low
  od_out_low: assert property (@(posedge clk_i) disable iff (rst_i)
    (mio_pad_out_o & OpenDrainMask) == '0)
    else begin
      fail_cnt++;
      $error("Open drain MIO pad drives a high level");
    end

  // TAP stays in reset with the overlay off
  trst_held: assert property (@(posedge clk_i) disable iff (rst_i)
    !jtag_active_o |-> !jtag_trst_no)
    else begin
      fail_cnt++;
      $error("TRST released while JTAG overlay is inactive");
    end

endmodule

bind pad_ring_top tb_pad_ring_sva u_sva (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .mio_pad_out_o ( mio_pad_out_o ),
  .dio_pad_out_o ( dio_pad_out_o ),
  .dio_pad_oe_o  ( dio_pad_oe_o  ),
  .jtag_trst_no  ( jtag_trst_no  ),
  .jtag_active_o ( jtag_active_o )
);

// File: tb_pad_ring.sv
//////////////////////////////////////////////////
// Pad ring testbench
// Random stimulus checked against a cycle model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pad_settings.svh"

module tb_pad_ring;

  import pad_pkg::*;
  import jtag_pkg::*;

  localparam int TimeoutCycles = 5 * 200 + 50; // 5 tests of up to 200 cycles
  localparam int Depth         = 5;            // Pad flops see a 4 cycle old strap

  // One cycle of stimulus in the order of the input concatenation
  typedef struct packed {
    mio_vec_t  mpad;
    mio_vec_t  mout;
    mio_vec_t  moe;
    mio_vec_t  minv;
    dio_vec_t  dpad;
    dio_vec_t  dout;
    dio_vec_t  doe;
    dio_vec_t  dinv;
    usb_pair_t usb;
    logic      en;
    logic      tdo;
  } stim_t;

  logic      clk_i, rst_i;
  mio_vec_t  mio_pad_in_i, mio_out_i, mio_oe_i, mio_inv_i;
  dio_vec_t  dio_pad_in_i, dio_out_i, dio_oe_i, dio_inv_i;
  usb_pair_t usb_pad_i;
  logic      usb_rx_en_i, jtag_tdo_i;
  mio_vec_t  mio_pad_out_o, mio_pad_oe_o, mio_in_o;
  dio_vec_t  dio_pad_out_o, dio_pad_oe_o, dio_in_o;
  logic      jtag_tck_o, jtag_tms_o, jtag_trst_no, jtag_tdi_o;
  logic      jtag_active_o, usb_d_o, usb_se0_o;

  stim_t       hist [Depth];          // hist[k] was driven k cycles ago
  logic [31:0] lcg_state = 32'd43622;
  int          cycle_cnt = 0;
  int          n_tests = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          start_checks = 0;
  int          start_errors = 0;
  int          lat;                   // Strap to jtag_active_o in cycles
  string       test_name = "reset_state";

  pad_ring_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i; // 4 ns period
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("Timeout: the tests did not complete within %0d cycles", TimeoutCycles);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16]; // Upper half has the longer period
  endfunction

  function automatic stim_t pick_stimulus(input logic strap);
    logic [95:0] r;
    stim_t       s;
    r = {rand16(), rand16(), rand16(), rand16(), rand16(), rand16()};
    s = r[$bits(stim_t)-1:0];
    s.mpad[`JTAG_EN_IDX] = strap; // Strap pad picks the mode
    s.minv[`JTAG_EN_IDX] = 1'b0;  // Strap read as is
    return s;
  endfunction

  task automatic drive(input stim_t s);
    {mio_pad_in_i, mio_out_i, mio_oe_i, mio_inv_i, dio_pad_in_i, dio_out_i, dio_oe_i,
     dio_inv_i, usb_pad_i, usb_rx_en_i, jtag_tdo_i} <= s;
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_mio(input string sig, input mio_vec_t exp, input mio_vec_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name, sig, exp, act);
    end
  endtask

  task automatic check_dio(input string sig, input dio_vec_t exp, input dio_vec_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name, sig, exp, act);
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error [%s] %s: expected %b, actual %b", test_name, sig, exp, act);
    end
  endtask

  task automatic check_mode(input string sig, input jtag_mode_e exp, input jtag_mode_e act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error [%s] %s: expected %s, actual %s", test_name, sig, exp.name(),
               act.name());
    end
  endtask

  task automatic check_reset_outputs();
    check_mio("mio_pad_out_o", '0, mio_pad_out_o);
    check_mio("mio_pad_oe_o", '0, mio_pad_oe_o);
    check_dio("dio_pad_out_o", '0, dio_pad_out_o);
    check_dio("dio_pad_oe_o", '0, dio_pad_oe_o);
    check_mode("jtag_active_o", JTAG_OFF, jtag_mode_e'(jtag_active_o));
    check_bit("jtag_trst_no", 1'b0, jtag_trst_no);
    check_bit("usb_d_o", 1'b0, usb_d_o);
    check_bit("usb_se0_o", 1'b0, usb_se0_o);
  endtask

  //////////////////////////////////////////////////
  // One cycle of stimulus plus the model check
  //////////////////////////////////////////////////

  task automatic run_cycle(input logic strap);
    stim_t    s;
    mio_vec_t raw, e_in, m_out, m_oe, e_out, e_oe;
    dio_vec_t e_dout, e_doe;
    logic     on_c, on_p, v;
    s = pick_stimulus(strap);
    @(posedge clk_i);
    drive(s);
    for (int k = Depth - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0] = s;
    @(negedge clk_i);
    on_c  = hist[3].mpad[`JTAG_EN_IDX];  // Sync plus mode register
    on_p  = hist[4].mpad[`JTAG_EN_IDX];  // Mode one cycle earlier as seen by the pad flops
    raw   = hist[2].mpad ^ hist[0].minv; // Invert applied after the sync
    e_in  = raw;
    m_out = hist[1].mout;
    m_oe  = hist[1].moe;
    if (on_c) begin
      e_in[`JTAG_TCK_IDX]  = 1'b0;
      e_in[`JTAG_TMS_IDX]  = 1'b0;
      e_in[`JTAG_TRST_IDX] = 1'b0;
      e_in[`JTAG_TDI_IDX]  = 1'b0;
      e_in[`JTAG_TDO_IDX]  = 1'b0;
    end
    if (on_p) begin
      m_oe[`JTAG_TCK_IDX]  = 1'b0;
      m_oe[`JTAG_TMS_IDX]  = 1'b0;
      m_oe[`JTAG_TRST_IDX] = 1'b0;
      m_oe[`JTAG_TDI_IDX]  = 1'b0;
      m_out[`JTAG_TDO_IDX] = hist[1].tdo; // TDO owns MIO 4
      m_oe[`JTAG_TDO_IDX]  = 1'b1;
    end
    for (int i = 0; i < `PAD_NUM_MIO; i++) begin
      v        = m_out[i] ^ hist[1].minv[i];
      e_out[i] = (i < 12) ? v : 1'b0;                   // 12-15 open drain
      e_oe[i]  = (i < 12) ? m_oe[i] : (m_oe[i] & ~v);   // Pull low only
    end
    for (int i = 0; i < `PAD_NUM_DIO; i++) begin
      v         = hist[1].dout[i] ^ hist[1].dinv[i];
      e_dout[i] = (i < 4) ? v : 1'b0;                   // CSB and SCK input only
      e_doe[i]  = (i < 4) ? hist[1].doe[i] : 1'b0;
    end
    check_mio("mio_in_o", e_in, mio_in_o);
    check_mio("mio_pad_out_o", e_out, mio_pad_out_o);
    check_mio("mio_pad_oe_o", e_oe, mio_pad_oe_o);
    check_dio("dio_in_o", hist[2].dpad ^ hist[0].dinv, dio_in_o);
    check_dio("dio_pad_out_o", e_dout, dio_pad_out_o);
    check_dio("dio_pad_oe_o", e_doe, dio_pad_oe_o);
    check_mode("jtag_active_o", on_c ? JTAG_ON : JTAG_OFF, jtag_mode_e'(jtag_active_o));
    check_bit("jtag_tck_o", on_c & raw[`JTAG_TCK_IDX], jtag_tck_o);
    check_bit("jtag_tms_o", on_c & raw[`JTAG_TMS_IDX], jtag_tms_o);
    check_bit("jtag_trst_no", on_c & raw[`JTAG_TRST_IDX], jtag_trst_no);
    check_bit("jtag_tdi_o", on_c & raw[`JTAG_TDI_IDX], jtag_tdi_o);
    check_bit("usb_d_o", hist[1].en & hist[3].usb.dp, usb_d_o);
    check_bit("usb_se0_o", hist[1].en & ~hist[3].usb.dp & ~hist[3].usb.dn, usb_se0_o);
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    start_checks = n_checks;
    start_errors = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("[%s] %0d checks, %0d errors", test_name, n_checks - start_checks,
             n_errors - start_errors);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_i = 1'b1;
    {mio_pad_in_i, mio_out_i, mio_oe_i, mio_inv_i, dio_pad_in_i, dio_out_i, dio_oe_i,
     dio_inv_i, usb_pad_i, usb_rx_en_i, jtag_tdo_i} = '0;
    for (int k = 0; k < Depth; k++) begin
      hist[k] = '0;
    end

    // Random inputs and a high strap while in reset
    begin_test("reset_state");
    repeat (3) begin
      @(posedge clk_i);
      drive(pick_stimulus(1'b1));
      @(negedge clk_i);
      check_reset_outputs();
    end
    @(posedge clk_i);
    rst_i <= 1'b0;
    drive('0);             // Model history starts all zero
    @(negedge clk_i);
    check_reset_outputs(); // First cycle out of reset
    end_test();

    begin_test("normal_outputs");
    repeat (150) run_cycle(1'b0);
    end_test();

    begin_test("normal_inputs");
    repeat (150) run_cycle(1'b0);
    end_test();

    begin_test("jtag_overlay");
    run_cycle(1'b1); // Strap rises
    lat = 0;
    while (jtag_active_o !== 1'b1) begin
      run_cycle(1'b1);
      lat++;
    end
    n_checks++;
    if (lat != 3) begin
      n_errors++;
      $display("** Error [%s] jtag_active_o latency: expected %0d, actual %0d", test_name,
               3, lat);
    end
    repeat (120) run_cycle(1'b1);
    repeat (40) run_cycle(1'b0); // Back to pass through
    end_test();

    begin_test("usb_rx");
    repeat (150) run_cycle(1'b0);
    end_test();

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", n_tests, n_checks,
             n_errors, dut_i.u_sva.fail_cnt);
    if (n_errors == 0 && dut_i.u_sva.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+.
pad_pkg.sv
jtag_pkg.sv
pad_sync.sv
pad_drv.sv
jtag_overlay_ctrl.sv
jtag_overlay_mux.sv
usb_diff_rx.sv
pad_ring_top.sv
tb_pad_ring_sva.sv
tb_pad_ring.sv
